//--- dv/uart_io_sva.sv
// bound into uart_io so it sees internal busy, strobe and rx_valid
// busy length is counted in cycles, so clks_per_bit must match the dut
// all checks are off while reset is high
`timescale 1ns/100ps

module uart_io_sva
   import uart_pkg::*;
   import io_bus_pkg::*;
#(
   parameter int clks_per_bit = default_clks_per_bit
) (
   input logic    clk,
   input logic    reset,
   input io_req_t req,
   input logic    tx_busy,
   input logic    txd,
   input logic    rx_strobe,
   input logic    rx_valid
);

   localparam int frame_cycles = 10 * clks_per_bit;  // start, 8 data, stop

   logic [31:0] busy_len;  // cycles of the current busy period
   logic        data_rd;
   int          fail_cnt;  // failed assertions so far

   assign data_rd = req.sel && req.rstrb && (req.reg_off == reg_data);

   always_ff @(posedge clk) begin
      if (reset) busy_len <= '0;
      else if (tx_busy) busy_len <= busy_len + 32'd1;
      else busy_len <= '0;  // restarts with the next frame
   end

   idle_line_high: assert property (@(posedge clk) disable iff (reset)
      !tx_busy |-> txd)
      else begin
         $error("txd low while the transmitter is idle");
         fail_cnt++;
      end

   // busy_len still holds the full count in the cycle busy is seen low
   busy_one_frame: assert property (@(posedge clk) disable iff (reset)
      $fell(tx_busy) |-> (busy_len == 32'(frame_cycles)))
      else begin
         $error("tx_busy lasted %0d cycles", busy_len);
         fail_cnt++;
      end

   valid_cleared: assert property (@(posedge clk) disable iff (reset)
      (data_rd && !rx_strobe) |=> !rx_valid)
      else begin
         $error("rx_valid still set after a data read");
         fail_cnt++;
      end

endmodule

//--- dv/uart_io_tb.sv
// testbench for uart_io with clks_per_bit = 16
// bus inputs and rxd change 2 ns after the rising edge, rdata and txd
// are sampled on the falling edge; a timeout counts as an error
`timescale 1ns/100ps

module uart_io_tb
   import uart_pkg::*;
   import io_bus_pkg::*;
();

   localparam int cpb          = 16;
   localparam int frame_cycles = 10 * cpb;
   localparam int poll_limit   = 400;  // bus polls before giving up
   localparam int n_bytes      = 20;

   logic        clk;
   logic        reset;
   io_req_t     req;
   logic [31:0] rdata;
   logic        rxd;
   logic        txd;

   int errors;
   int tests;
   int failed_tests;
   int err_base;  // error count at the start of the current test
   int sva_seen;  // bound assertion failures already counted

   uart_io #(.clks_per_bit(cpb)) dut (
      .clk   (clk),
      .reset (reset),
      .req   (req),
      .rdata (rdata),
      .rxd   (rxd),
      .txd   (txd)
   );

   bind uart_io uart_io_sva #(.clks_per_bit(clks_per_bit)) u_sva (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .tx_busy   (tx_busy),
      .txd       (txd),
      .rx_strobe (rx_strobe),
      .rx_valid  (u_regs.rx_valid)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns period
   end

   task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp);
      end
   endtask

   task automatic check_status(input string name, input uart_status_t got,
                               input uart_status_t exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got 0x%01h expected 0x%01h", name, got, exp);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got 0x%01h expected 0x%01h", name, got, exp);
      end
   endtask

   function automatic uart_status_t make_status(input logic fe, input logic ov,
                                                input logic busy, input logic valid);
      return '{frame_err: fe, overrun: ov, tx_busy: busy, rx_valid: valid};
   endfunction

   // byte in 7..0, status above it, zero on top
   function automatic logic [31:0] expect_word(input uart_status_t st, input uart_byte_t b);
      logic [31:0] w;
      w = '0;
      w[status_lsb +: $bits(uart_status_t)] = st;
      w[7:0] = b;
      return w;
   endfunction

   function automatic uart_status_t status_field(input logic [31:0] w);
      return uart_status_t'(w[status_lsb +: $bits(uart_status_t)]);
   endfunction

   // bus tasks start and end 2 ns after a rising edge
   task automatic bus_write(input logic off, input logic [31:0] data);
      req         = '0;
      req.sel     = 1'b1;
      req.wstrb   = 1'b1;
      req.reg_off = off;
      req.wdata   = data;
      @(posedge clk);  // accepted here
      #2;
      req = '0;
   endtask

   task automatic bus_read(input logic off, output logic [31:0] data);
      req         = '0;
      req.sel     = 1'b1;
      req.rstrb   = 1'b1;
      req.reg_off = off;
      @(negedge clk);
      data = rdata;  // combinational, taken before the clearing edge
      @(posedge clk);
      #2;
      req = '0;
   endtask

   task automatic wait_tx_idle(output logic [31:0] w);
      int polls;
      polls = 0;
      bus_read(reg_ctrl, w);
      while (status_field(w).tx_busy && polls < poll_limit) begin
         bus_read(reg_ctrl, w);
         polls++;
      end
      if (status_field(w).tx_busy) begin
         errors++;
         $display("timeout: transmitter still busy after %0d polls", polls);
      end
   endtask

   task automatic wait_rx_valid(output logic [31:0] w);
      int polls;
      polls = 0;
      bus_read(reg_ctrl, w);
      while (!status_field(w).rx_valid && polls < poll_limit) begin
         bus_read(reg_ctrl, w);
         polls++;
      end
      if (!status_field(w).rx_valid) begin
         errors++;
         $display("timeout: no received byte after %0d polls", polls);
      end
   endtask

   // drives one frame on rxd, start bit then lsb first, stop bit as given
   task automatic send_frame(input uart_byte_t b, input logic stop);
      logic [9:0] bits;
      bits = {stop, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         rxd = bits[i];
         repeat (cpb) @(posedge clk);
         #2;
      end
      rxd = 1'b1;
      repeat (cpb) @(posedge clk);  // one idle bit
      #2;
   endtask

   // finds the start bit, then samples txd in the middle of each bit
   task automatic decode_txd(output uart_byte_t b);
      int waited;
      b = '0;
      waited = 0;
      @(negedge clk);
      while (txd !== 1'b0 && waited < frame_cycles) begin
         @(negedge clk);
         waited++;
      end
      if (txd !== 1'b0) begin
         errors++;
         $display("timeout: no start bit on txd");
      end else begin
         repeat (cpb / 2) @(negedge clk);
         check_bit("txd start bit", txd, 1'b0);
         for (int i = 0; i < 8; i++) begin
            repeat (cpb) @(negedge clk);
            b[i] = txd;
         end
         repeat (cpb) @(negedge clk);
         check_bit("txd stop bit", txd, 1'b1);
      end
   endtask

   task automatic end_test(input string name);
      errors += dut.u_sva.fail_cnt - sva_seen;  // assertions that fired in this test
      sva_seen = dut.u_sva.fail_cnt;
      tests++;
      if (errors > err_base) begin
         failed_tests++;
         $display("test %s: %0d errors", name, errors - err_base);
      end else begin
         $display("test %s: ok", name);
      end
      err_base = errors;
   endtask

   task automatic reset_state();
      logic [31:0] w;
      bus_read(reg_data, w);
      check_status("data status", status_field(w), make_status(0, 0, 0, 0));
      bus_read(reg_ctrl, w);
      check_word("ctrl rdata", w, '0);
      check_bit("txd", txd, 1'b1);  // idle line
      end_test("reset");
   endtask

   task automatic transmit_bytes();
      uart_byte_t  b;
      uart_byte_t  got;
      logic [31:0] w;
      for (int n = 0; n < n_bytes; n++) begin
         b = uart_byte_t'($urandom());
         fork
            decode_txd(got);
            begin
               bus_write(reg_data, {24'($urandom()), b});  // upper bits ignored
               repeat (1 + $urandom_range(0, 100)) @(posedge clk);
               #2;
               bus_read(reg_ctrl, w);
               check_status("status in frame", status_field(w), make_status(0, 0, 1, 0));
            end
         join
         @(posedge clk);  // back to the drive point
         #2;
         check_byte("txd byte", got, b);
         wait_tx_idle(w);
         check_word("ctrl after frame", w, '0);
      end
      end_test("transmit");
   endtask

   task automatic write_while_busy();
      uart_byte_t  b;
      uart_byte_t  got;
      logic [31:0] w;
      logic        idle_ok;
      b = uart_byte_t'($urandom());
      fork
         decode_txd(got);
         begin
            bus_write(reg_data, {24'h0, b});
            repeat (20 + $urandom_range(0, 120)) @(posedge clk);
            #2;
            bus_write(reg_data, {24'h0, ~b});  // lands while busy
         end
      join
      check_byte("txd byte", got, b);
      idle_ok = 1'b1;
      for (int i = 0; i < frame_cycles; i++) begin
         @(negedge clk);
         if (txd !== 1'b1) idle_ok = 1'b0;
      end
      if (!idle_ok) begin
         errors++;
         $display("txd left idle after a write to a busy transmitter");
      end
      @(posedge clk);
      #2;
      wait_tx_idle(w);
      end_test("write while busy");
   endtask

   task automatic receive_bytes();
      uart_byte_t  b;
      logic [31:0] w;
      for (int n = 0; n < n_bytes; n++) begin
         b = uart_byte_t'($urandom());
         repeat ($urandom_range(1, 20)) @(posedge clk);  // random line idle
         #2;
         send_frame(b, 1'b1);
         wait_rx_valid(w);
         check_word("ctrl rdata", w, expect_word(make_status(0, 0, 0, 1), 8'h00));
         bus_read(reg_data, w);
         check_byte("rx byte", w[7:0], b);
         check_word("data rdata", w, expect_word(make_status(0, 0, 0, 1), b));
         bus_read(reg_ctrl, w);
         check_status("status after read", status_field(w), make_status(0, 0, 0, 0));
      end
      end_test("receive");
   endtask

   task automatic overrun_bytes();
      uart_byte_t  first;
      uart_byte_t  second;
      logic [31:0] w;
      first  = uart_byte_t'($urandom());
      second = uart_byte_t'($urandom());
      send_frame(first, 1'b1);
      send_frame(second, 1'b1);  // no read in between
      bus_read(reg_data, w);
      check_byte("rx byte", w[7:0], second);
      check_status("overrun status", status_field(w), make_status(0, 1, 0, 1));
      bus_read(reg_ctrl, w);
      check_status("status after read", status_field(w), make_status(0, 0, 0, 0));
      end_test("overrun");
   endtask

   task automatic bad_stop_bit();
      logic [31:0] w;
      send_frame(uart_byte_t'($urandom()), 1'b0);  // stop bit low
      bus_read(reg_ctrl, w);
      check_status("frame status", status_field(w), make_status(1, 0, 0, 0));
      bus_read(reg_ctrl, w);
      check_status("status after read", status_field(w), make_status(0, 0, 0, 0));
      end_test("framing error");
   endtask

   initial begin
      void'($urandom(32'he4eb_7207));
      errors       = 0;
      tests        = 0;
      failed_tests = 0;
      err_base     = 0;
      sva_seen     = 0;
      req          = '0;
      rxd          = 1'b1;
      reset        = 1'b1;
      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;
      reset_state();
      transmit_bytes();
      write_while_busy();
      receive_bytes();
      overrun_bytes();
      bad_stop_bit();
      $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the uart_io testbench with Verilator and runs it
set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -f verilog.f --top-module uart_io_tb \
   -Mdir obj_dir -o uart_io_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/uart_io_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "TEST FAIL" "$log"; then
   exit 1
fi
exit 0

//--- verilog.f
verilog/uart_pkg.sv
verilog/io_bus_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_regs.sv
verilog/uart_io.sv
dv/uart_io_sva.sv
dv/uart_io_tb.sv

//--- verilog/io_bus_pkg.sv
// cpu side of the peripheral bus, plain level strobes
// system address decode is outside, it arrives as one select
// only one register offset bit is decoded
// read data is combinational and valid while sel is high
package io_bus_pkg;

   // one bus request, sampled every cycle
   typedef struct packed {
      logic        rstrb;    // read strobe
      logic        wstrb;    // write strobe
      logic        sel;      // port selected by system decode
      logic        reg_off;  // register offset within the port
      logic [31:0] wdata;    // write data, byte in bits 7..0
   } io_req_t;

   // register offsets
   localparam logic reg_data = 1'b0;  // rw, byte plus status
   localparam logic reg_ctrl = 1'b1;  // ro, status only

   // status field sits right above the byte in read data
   // bits above the status field read as zero
   localparam int status_lsb = 8;

endpackage

//--- verilog/uart_io.sv
// memory-mapped serial port, top level
// one slave on a single-master bus, select comes from system decode
// clks_per_bit sets the baud rate for both directions, fixed at build
// software polls tx_busy and rx_valid, there is no interrupt
`timescale 1ns/100ps

module uart_io
   import uart_pkg::*;
   import io_bus_pkg::*;
#(
   parameter int clks_per_bit = default_clks_per_bit
) (
   input  logic        clk,
   input  logic        reset,
   input  io_req_t     req,    // cpu request
   output logic [31:0] rdata,  // combinational read data
   input  logic        rxd,    // serial in, async
   output logic        txd     // serial out
);

   logic       tx_start;
   uart_byte_t tx_byte;
   logic       tx_busy;
   logic       rx_strobe;
   uart_byte_t rx_byte;
   logic       rx_frame_err;

   uart_regs u_regs (
      .clk          (clk),
      .reset        (reset),
      .req          (req),
      .rdata        (rdata),
      .tx_start     (tx_start),
      .tx_byte      (tx_byte),
      .tx_busy      (tx_busy),
      .rx_strobe    (rx_strobe),
      .rx_byte      (rx_byte),
      .rx_frame_err (rx_frame_err)
   );

   uart_rx #(.clks_per_bit(clks_per_bit)) u_rx (
      .clk          (clk),
      .reset        (reset),
      .rxd          (rxd),
      .rx_strobe    (rx_strobe),
      .rx_byte      (rx_byte),
      .rx_frame_err (rx_frame_err)
   );

   uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
      .clk      (clk),
      .reset    (reset),
      .tx_start (tx_start),
      .tx_byte  (tx_byte),
      .tx_busy  (tx_busy),
      .txd      (txd)
   );

endmodule

//--- verilog/uart_pkg.sv
// serial line types shared by the receiver, transmitter and register block
// frames are 8N1 only; no parity, no configurable width
// default bit period assumes a 50 MHz clock and 115200 baud
// clks_per_bit below 4 is not supported by the mid-bit sampling
package uart_pkg;

   // one data byte on the wire, sent lsb first
   typedef logic [7:0] uart_byte_t;

   // status flags as seen by software
   // order fixes the bit layout inside the read word
   typedef struct packed {
      logic frame_err;  // sticky, bad stop bit seen
      logic overrun;    // byte replaced before it was read
      logic tx_busy;    // live, frame on txd
      logic rx_valid;   // unread byte waiting
   } uart_status_t;

   // clock cycles per serial bit
   // 50e6 / 115200 rounds to 434
   localparam int default_clks_per_bit = 434;

endpackage

//--- verilog/uart_regs.sv
// cpu-visible registers of the serial port
// an access is any cycle with sel and a strobe high, so the cpu
// must hold a read strobe for one cycle only or flags clear early
// a data write while the transmitter is busy is dropped
`timescale 1ns/100ps

module uart_regs
   import uart_pkg::*;
   import io_bus_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  io_req_t     req,
   output logic [31:0] rdata,        // combinational
   output logic        tx_start,
   output uart_byte_t  tx_byte,
   input  logic        tx_busy,
   input  logic        rx_strobe,
   input  uart_byte_t  rx_byte,
   input  logic        rx_frame_err
);

   logic         rd_access;
   logic         wr_access;
   logic         data_rd;     // clears rx_valid and overrun
   logic         ctrl_rd;     // clears frame_err
   logic         data_wr;
   logic         rx_valid;
   logic         overrun;
   logic         frame_err;
   uart_byte_t   rx_data;     // newest good byte
   uart_status_t status;

   assign rd_access = req.sel & req.rstrb;
   assign wr_access = req.sel & req.wstrb;
   assign data_rd   = rd_access && (req.reg_off == reg_data);
   assign ctrl_rd   = rd_access && (req.reg_off == reg_ctrl);
   assign data_wr   = wr_access && (req.reg_off == reg_data);

   assign tx_start = data_wr & ~tx_busy;  // busy write dropped here
   assign tx_byte  = req.wdata[$bits(uart_byte_t)-1:0];

   // set wins over clear, a byte landing during a read stays valid
   always_ff @(posedge clk) begin
      if (reset) begin
         rx_valid  <= 1'b0;
         overrun   <= 1'b0;
         frame_err <= 1'b0;
      end else begin
         if (rx_strobe) rx_valid <= 1'b1;
         else if (data_rd) rx_valid <= 1'b0;

         // only an unread old byte counts as overrun
         if (rx_strobe && rx_valid && !data_rd) overrun <= 1'b1;
         else if (data_rd) overrun <= 1'b0;

         if (rx_frame_err) frame_err <= 1'b1;
         else if (ctrl_rd) frame_err <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rx_strobe) rx_data <= rx_byte;  // replaces any unread byte
   end

   assign status = '{frame_err: frame_err,
                     overrun:   overrun,
                     tx_busy:   tx_busy,
                     rx_valid:  rx_valid};

   // byte field only on the data register, zero above status
   always_comb begin
      rdata = '0;
      if (req.sel) begin
         rdata[status_lsb +: $bits(uart_status_t)] = status;
         if (req.reg_off == reg_data) rdata[$bits(uart_byte_t)-1:0] = rx_data;
      end
   end

endmodule

//--- verilog/uart_rx.sv
// serial receiver, 8N1, lsb first
// line is synchronized by two flops before use
// a start is a falling edge, so a stuck low line after a bad stop bit
// does not restart the receiver; clks_per_bit must be 4 or more
`timescale 1ns/100ps

module uart_rx
   import uart_pkg::*;
#(
   parameter int clks_per_bit = default_clks_per_bit
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       rxd,          // async serial input
   output logic       rx_strobe,    // one cycle, byte good
   output uart_byte_t rx_byte,      // valid with rx_strobe
   output logic       rx_frame_err  // one cycle, stop bit low
);

   localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
   localparam logic [cnt_w-1:0] last_cyc = cnt_w'(clks_per_bit - 1);
   localparam logic [cnt_w-1:0] half_cyc = cnt_w'(clks_per_bit / 2 - 1);
   localparam int idx_w = $clog2($bits(uart_byte_t));
   localparam logic [idx_w-1:0] last_bit = idx_w'($bits(uart_byte_t) - 1);

   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_data,
      st_stop
   } rx_state_t;

   rx_state_t        state;
   logic [1:0]       sync;     // metastability chain
   logic             rxd_s;    // synchronized line
   logic             rxd_q;    // previous synchronized value
   logic             fall;     // start edge
   logic [cnt_w-1:0] cyc_cnt;  // cycles within the current bit
   logic [idx_w-1:0] bit_idx;  // data bit being received

   assign rxd_s = sync[1];
   assign fall  = rxd_q & ~rxd_s;

   // line idles high, so reset to 1 to avoid a false start
   always_ff @(posedge clk) begin
      if (reset) begin
         sync  <= 2'b11;
         rxd_q <= 1'b1;
      end else begin
         sync  <= {sync[0], rxd};
         rxd_q <= rxd_s;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= st_idle;
         cyc_cnt      <= '0;
         bit_idx      <= '0;
         rx_strobe    <= 1'b0;
         rx_frame_err <= 1'b0;
      end else begin
         rx_strobe    <= 1'b0;  // pulses only
         rx_frame_err <= 1'b0;
         case (state)
            st_idle: begin
               if (fall) begin
                  state   <= st_start;
                  cyc_cnt <= '0;
               end
            end
            st_start: begin
               if (cyc_cnt == half_cyc) begin  // middle of start bit
                  cyc_cnt <= '0;
                  bit_idx <= '0;
                  state   <= rxd_s ? st_idle : st_data;  // high again = glitch
               end else begin
                  cyc_cnt <= cyc_cnt + 1'b1;
               end
            end
            st_data: begin
               if (cyc_cnt == last_cyc) begin  // middle of a data bit
                  cyc_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == last_bit) state <= st_stop;
               end else begin
                  cyc_cnt <= cyc_cnt + 1'b1;
               end
            end
            st_stop: begin
               if (cyc_cnt == last_cyc) begin  // middle of stop bit
                  rx_strobe    <= rxd_s;
                  rx_frame_err <= ~rxd_s;       // byte dropped
                  state        <= st_idle;
               end else begin
                  cyc_cnt <= cyc_cnt + 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // data shifts in from the top, lsb arrives first
   // byte is stable from the last data bit until the next frame
   always_ff @(posedge clk) begin
      if (state == st_data && cyc_cnt == last_cyc) begin
         rx_byte <= {rxd_s, rx_byte[$bits(uart_byte_t)-1:1]};
      end
   end

endmodule

//--- verilog/uart_tx.sv
// serial transmitter, 8N1, lsb first
// tx_start is ignored while busy, the caller polls busy
// txd comes straight from a flop
// busy covers the whole frame, 10 x clks_per_bit cycles
`timescale 1ns/100ps

module uart_tx
   import uart_pkg::*;
#(
   parameter int clks_per_bit = default_clks_per_bit
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       tx_start,  // one cycle, load and go
   input  uart_byte_t tx_byte,
   output logic       tx_busy,
   output logic       txd
);

   localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
   localparam logic [cnt_w-1:0] last_cyc = cnt_w'(clks_per_bit - 1);
   localparam int frame_bits = $bits(uart_byte_t) + 2;  // start, data, stop
   localparam int left_w = $clog2(frame_bits);

   // stop bit and data; the start bit goes to txd at load time
   logic [$bits(uart_byte_t):0] shreg;
   logic [cnt_w-1:0]            cyc_cnt;    // counts down within a bit
   logic [left_w-1:0]           bits_left;  // bits after the current one
   logic                        load;
   logic                        bit_end;

   assign load    = tx_start & ~tx_busy;
   assign bit_end = tx_busy && (cyc_cnt == '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         tx_busy   <= 1'b0;
         txd       <= 1'b1;  // idle line
         cyc_cnt   <= '0;
         bits_left <= '0;
      end else if (load) begin
         tx_busy   <= 1'b1;
         txd       <= 1'b0;  // start bit at the next edge
         cyc_cnt   <= last_cyc;
         bits_left <= left_w'(frame_bits - 1);
      end else if (tx_busy) begin
         if (cyc_cnt != '0) begin
            cyc_cnt <= cyc_cnt - 1'b1;
         end else if (bits_left == '0) begin
            tx_busy <= 1'b0;  // last stop-bit cycle done
         end else begin
            txd       <= shreg[0];
            cyc_cnt   <= last_cyc;
            bits_left <= bits_left - 1'b1;
         end
      end
   end

   // fills with ones so txd rests high after the stop bit
   always_ff @(posedge clk) begin
      if (load) begin
         shreg <= {1'b1, tx_byte};
      end else if (bit_end && bits_left != '0) begin
         shreg <= {1'b1, shreg[$bits(uart_byte_t):1]};
      end
   end

endmodule
